//--- build.f
common/i2s_pkg.sv
hw/i2s_pin_sync.sv
i2s_in/i2s_deserializer.sv
i2s_in/i2s_bist_gen.sv
i2s_in/i2s_sample_buffer.sv
hw/i2s_in_top.sv
bench/tb_i2s_in.sv

//--- bench/tb_i2s_in.sv
`timescale 1ns/1ps

module tb_i2s_in;

    import i2s_pkg::*;

    localparam int frame_cycles = 512;           // 32 bit clocks of 16 clk each
    localparam int max_cycles   = 20000;         // About 24 frames of traffic plus margin

    logic       clk;
    logic       rst_n;
    logic       sck;
    logic       ws;
    logic       sd;
    logic       i2s_en;
    logic       bist_sel;
    bist_cfg_t  bist_cfg;
    logic       out_ready;
    logic       overrun_clr;
    logic       underrun_clr;
    logic       out_valid;
    sample_t    out_sample;
    logic       overrun;
    logic       underrun;

    ds_state_e  ds_state;                        // Deserializer position for progress lines
    sample_t    exp_q [$];
    logic [31:0] lcg_state = 32'h3524454b;
    logic       last_lsb = 1'b0;                 // Right LSB still owed to the next frame
    int         cycle_cnt = 0;

    assign ds_state = u_i2s_in_top.u_deserializer.state;

    i2s_in_top #(
        .fifo_depth_log2 (3)
    ) u_i2s_in_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .sck          (sck),
        .ws           (ws),
        .sd           (sd),
        .i2s_en       (i2s_en),
        .bist_sel     (bist_sel),
        .bist_cfg     (bist_cfg),
        .out_ready    (out_ready),
        .overrun_clr  (overrun_clr),
        .underrun_clr (underrun_clr),
        .out_valid    (out_valid),
        .out_sample   (out_sample),
        .overrun      (overrun),
        .underrun     (underrun)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= max_cycles)
            fail_run($sformatf("Run did not finish within %0d clk cycles", max_cycles));
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
            fail_run($sformatf("** Error: %s expected 0x%h, got 0x%h", name, expected, actual));
    endtask

    // Move to 0.5 ns after the next rising edge
    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    function automatic logic [15:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];                 // Upper bits are the better ones
    endfunction

    //////////////////////////////////////////////////////////////////////
    // I2S transmitter
    //////////////////////////////////////////////////////////////////////

    // One bit clock period with ws and sd changing on the falling edge
    task automatic send_period(input logic ws_v, input logic sd_v);
        step();
        sck = 1'b0;
        ws  = ws_v;
        sd  = sd_v;
        repeat (8) @(posedge clk);
        #0.5;
        sck = 1'b1;
        repeat (7) @(posedge clk);
        #0.5;
    endtask

    // Frames below n_skip are sent but not expected at the output
    task automatic send_frames(input int n_frames, input int n_skip);
        sample_t pair;
        int      f;
        int      b;
        for (f = 0; f < n_frames; f++)
        begin
            pair.left  = rand_word();
            pair.right = rand_word();
            if (f >= n_skip)
                exp_q.push_back(pair);
            send_period(1'b0, last_lsb);         // One-bit delay after ws falls
            for (b = word_w - 1; b >= 1; b--)
                send_period(1'b0, pair.left[b]);
            send_period(1'b1, pair.left[0]);
            for (b = word_w - 1; b >= 1; b--)
                send_period(1'b1, pair.right[b]);
            last_lsb = pair.right[0];
        end
        send_period(1'b0, last_lsb);             // Trailing ws fall closes the last frame
    endtask

    task automatic read_pairs(input int n);
        sample_t want;
        int      wait_cnt;
        int      i;
        for (i = 0; i < n; i++)
        begin
            wait_cnt = 0;
            while (!out_valid)
            begin
                step();
                wait_cnt++;
                assert (wait_cnt < 4 * frame_cycles)
                else
                    fail_run("Timed out waiting for out_valid");
            end
            want = exp_q.pop_front();
            check_value("out_sample.left", want.left, out_sample.left);
            check_value("out_sample.right", want.right, out_sample.right);
            out_ready = 1'b1;
            step();
            out_ready = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        $display("Reset state, deserializer %s", ds_state.name());
        check_value("out_valid", 0, out_valid);
        check_value("overrun", 0, overrun);
        check_value("underrun", 0, underrun);
        check_value("ds_state", ds_idle, ds_state);
    endtask

    task automatic test_capture();
        i2s_en = 1'b1;
        send_frames(5, 1);                       // Priming frame plus 4
        $display("Capture sent, deserializer %s", ds_state.name());
        read_pairs(4);
        step();
        check_value("out_valid", 0, out_valid);
    endtask

    task automatic test_disabled();
        i2s_en = 1'b0;
        send_frames(2, 2);
        repeat (8) step();
        $display("Disabled run done, deserializer %s", ds_state.name());
        check_value("out_valid", 0, out_valid);
        check_value("ds_state", ds_idle, ds_state);
    endtask

    task automatic test_overrun();
        i2s_en = 1'b1;
        send_frames(11, 1);                      // 10 pairs into 8 entries
        check_value("overrun", 1, overrun);
        read_pairs(8);
        step();
        check_value("out_valid", 0, out_valid);
        exp_q.delete();
        overrun_clr = 1'b1;
        step();
        overrun_clr = 1'b0;
        check_value("overrun", 0, overrun);
    endtask

    task automatic test_underrun();
        check_value("out_valid", 0, out_valid);
        out_ready = 1'b1;
        repeat (3) step();
        out_ready = 1'b0;
        check_value("underrun", 1, underrun);
        repeat (3) step();
        check_value("underrun", 1, underrun);    // Sticky
        underrun_clr = 1'b1;
        step();
        underrun_clr = 1'b0;
        check_value("underrun", 0, underrun);
    endtask

    task automatic test_bist();
        sample_t want;
        int      value;
        int      next_val;
        int      k;
        i2s_en             = 1'b0;
        bist_cfg.start_val = 12'h0F0;
        bist_cfg.inc       = 8'h40;
        bist_cfg.up_limit  = 12'h180;
        repeat (2) step();                       // Generator loads start_val while idle
        bist_sel = 1'b1;
        value = bist_cfg.start_val;
        for (k = 0; k < 6; k++)
        begin
            want.left  = value[word_w-1:0];
            want.right = value[word_w-1:0];
            exp_q.push_back(want);
            next_val = value + bist_cfg.inc;
            if (next_val > bist_cfg.up_limit)
                value = bist_cfg.start_val;      // Wrap above the limit
            else
                value = next_val;
        end
        send_frames(6, 6);                       // 193 bit clocks give 6 frame ends
        read_pairs(6);
        step();
        check_value("out_valid", 0, out_valid);
    endtask

    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        sck          = 1'b0;
        ws           = 1'b0;
        sd           = 1'b0;
        i2s_en       = 1'b0;
        bist_sel     = 1'b0;
        bist_cfg     = '0;
        out_ready    = 1'b0;
        overrun_clr  = 1'b0;
        underrun_clr = 1'b0;
        repeat (5) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        step();
        test_reset_state();
        test_capture();
        test_disabled();
        test_overrun();
        test_underrun();
        test_bist();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- hw/i2s_in_top.sv
`timescale 1ns/1ps

module i2s_in_top #(
    parameter int fifo_depth_log2 = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sck,
    input  logic               ws,
    input  logic               sd,
    input  logic               i2s_en,
    input  logic               bist_sel,
    input  i2s_pkg::bist_cfg_t bist_cfg,
    input  logic               out_ready,
    input  logic               overrun_clr,
    input  logic               underrun_clr,
    output logic               out_valid,
    output i2s_pkg::sample_t   out_sample,
    output logic               overrun,
    output logic               underrun
);

    import i2s_pkg::*;

    logic    sck_rise;                          // Bit clock edge in the clk domain
    logic    ws_s;
    logic    sd_s;
    sample_t ser_sample;
    logic    ser_strobe;
    sample_t bist_sample;
    logic    bist_strobe;

    //////////////////////////////////////////////////////////////////////
    // Pin input and sample sources
    //////////////////////////////////////////////////////////////////////

    i2s_pin_sync u_pin_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .sck        (sck),
        .ws         (ws),
        .sd         (sd),
        .sck_rise   (sck_rise),
        .ws_s       (ws_s),
        .sd_s       (sd_s)
    );

    i2s_deserializer u_deserializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (i2s_en),
        .sck_rise   (sck_rise),
        .ws_s       (ws_s),
        .sd_s       (sd_s),
        .ser_sample (ser_sample),
        .ser_strobe (ser_strobe)
    );

    i2s_bist_gen u_bist_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (bist_sel),                // Paced by the incoming bit clock
        .sck_rise    (sck_rise),
        .cfg         (bist_cfg),
        .bist_sample (bist_sample),
        .bist_strobe (bist_strobe)
    );

    //////////////////////////////////////////////////////////////////////
    // Output buffer
    //////////////////////////////////////////////////////////////////////

    i2s_sample_buffer #(
        .fifo_depth_log2 (fifo_depth_log2)
    ) u_sample_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .bist_sel     (bist_sel),
        .ser_sample   (ser_sample),
        .ser_strobe   (ser_strobe),
        .bist_sample  (bist_sample),
        .bist_strobe  (bist_strobe),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_sample   (out_sample),
        .overrun_clr  (overrun_clr),
        .underrun_clr (underrun_clr),
        .overrun      (overrun),
        .underrun     (underrun)
    );

endmodule

//--- i2s_in/i2s_sample_buffer.sv
`timescale 1ns/1ps

module i2s_sample_buffer #(
    parameter int fifo_depth_log2 = 3
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             bist_sel,
    input  i2s_pkg::sample_t ser_sample,
    input  logic             ser_strobe,
    input  i2s_pkg::sample_t bist_sample,
    input  logic             bist_strobe,
    input  logic             out_ready,
    output logic             out_valid,
    output i2s_pkg::sample_t out_sample,
    input  logic             overrun_clr,
    input  logic             underrun_clr,
    output logic             overrun,
    output logic             underrun
);

    import i2s_pkg::*;

    localparam int depth = 1 << fifo_depth_log2;

    sample_t                    mem [depth];
    sample_t                    wr_data;
    logic                       wr_strobe;
    logic [fifo_depth_log2-1:0] wr_ptr;
    logic [fifo_depth_log2-1:0] rd_ptr;
    logic [fifo_depth_log2:0]   count;
    logic                       full;
    logic                       push;
    logic                       pop;

    //////////////////////////////////////////////////////////////////////
    // Source select
    //////////////////////////////////////////////////////////////////////

    assign wr_data   = bist_sel ? bist_sample : ser_sample;
    assign wr_strobe = bist_sel ? bist_strobe : ser_strobe;

    //////////////////////////////////////////////////////////////////////
    // Circular buffer
    //////////////////////////////////////////////////////////////////////

    assign full       = (count == (fifo_depth_log2 + 1)'(depth));
    assign push       = wr_strobe & ~full;      // Audio cannot wait, so drop when full
    assign pop        = out_valid & out_ready;
    assign out_valid  = (count != '0);
    assign out_sample = mem[rd_ptr];            // Oldest entry

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Sticky status flags with set taking priority over clear
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            overrun  <= 1'b0;
            underrun <= 1'b0;
        end
        else
        begin
            if (wr_strobe && full)
                overrun <= 1'b1;
            else if (overrun_clr)
                overrun <= 1'b0;

            if (out_ready && !out_valid)
                underrun <= 1'b1;
            else if (underrun_clr)
                underrun <= 1'b0;
        end
    end

endmodule

//--- i2s_in/i2s_bist_gen.sv
`timescale 1ns/1ps

module i2s_bist_gen (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               active,
    input  logic               sck_rise,
    input  i2s_pkg::bist_cfg_t cfg,
    output i2s_pkg::sample_t   bist_sample,
    output logic               bist_strobe
);

    import i2s_pkg::*;

    logic [4:0]  edge_cnt;                      // 32 bit clocks per stereo frame
    logic [11:0] value_q;
    logic [12:0] sum;
    logic [11:0] next_value;
    logic        frame_end;

    assign sum        = {1'b0, value_q} + {5'd0, cfg.inc};
    assign next_value = (sum > {1'b0, cfg.up_limit}) ? cfg.start_val : sum[11:0];
    assign frame_end  = active & sck_rise & (edge_cnt == 5'd31);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            edge_cnt    <= '0;
            value_q     <= '0;
            bist_strobe <= 1'b0;
        end
        else if (!active)
        begin
            edge_cnt    <= '0;
            value_q     <= cfg.start_val;       // Restart pattern when reselected
            bist_strobe <= 1'b0;
        end
        else
        begin
            if (sck_rise)
                edge_cnt <= edge_cnt + 5'd1;    // Wraps after 31
            if (frame_end)
                value_q <= next_value;
            bist_strobe <= frame_end;
        end
    end

    // Same value in both channels, zero extended
    always_ff @(posedge clk)
    begin
        if (frame_end)
        begin
            bist_sample.left  <= {{(word_w-12){1'b0}}, value_q};
            bist_sample.right <= {{(word_w-12){1'b0}}, value_q};
        end
    end

endmodule

//--- i2s_in/i2s_deserializer.sv
`timescale 1ns/1ps

module i2s_deserializer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,
    input  logic             sck_rise,
    input  logic             ws_s,
    input  logic             sd_s,
    output i2s_pkg::sample_t ser_sample,
    output logic             ser_strobe
);

    import i2s_pkg::*;

    ds_state_e         state;
    logic              ws_d;                    // ws seen at the previous sck edge
    logic [word_w-1:0] shift_q;
    logic [word_w-1:0] word_now;                // Shift register including this edge
    logic [word_w-1:0] left_q;
    logic              ws_rise;
    logic              ws_fall;
    logic              pair_done;

    // With the one-bit I2S delay, the edge that sees ws change carries the LSB
    // of the word that just ended
    assign word_now  = {shift_q[word_w-2:0], sd_s};
    assign ws_rise   = sck_rise & ws_s & ~ws_d;
    assign ws_fall   = sck_rise & ~ws_s & ws_d;
    assign pair_done = en & (state == ds_right) & ws_fall;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ws_d <= 1'b0;
        else if (sck_rise)
            ws_d <= ws_s;
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise)
            shift_q <= word_now;                // MSB first
    end

    //////////////////////////////////////////////////////////////////////
    // Frame position
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ds_idle;
        else if (!en)
            state <= ds_idle;
        else
        begin
            case (state)
                ds_idle:  if (ws_fall) state <= ds_left;    // Partial frame dropped
                ds_left:  if (ws_rise) state <= ds_right;
                ds_right: if (ws_fall) state <= ds_left;
                default:  state <= ds_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == ds_left) && ws_rise)
            left_q <= word_now;
        if (pair_done)
        begin
            ser_sample.left  <= left_q;
            ser_sample.right <= word_now;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ser_strobe <= 1'b0;
        else
            ser_strobe <= pair_done;
    end

endmodule

//--- hw/i2s_pin_sync.sv
`timescale 1ns/1ps

module i2s_pin_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic sck,
    input  logic ws,
    input  logic sd,
    output logic sck_rise,
    output logic ws_s,
    output logic sd_s
);

    logic sck_meta;
    logic sck_s;
    logic sck_dly;
    logic ws_meta;
    logic sd_meta;

    // Two flop stages per pin with all three pins on the same stage
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_meta <= 1'b0;
            sck_s    <= 1'b0;
            ws_meta  <= 1'b0;
            ws_s     <= 1'b0;
            sd_meta  <= 1'b0;
            sd_s     <= 1'b0;
        end
        else
        begin
            sck_meta <= sck;
            sck_s    <= sck_meta;
            ws_meta  <= ws;
            ws_s     <= ws_meta;
            sd_meta  <= sd;
            sd_s     <= sd_meta;
        end
    end

    // Registered rising edge detect on the synchronized bit clock
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_dly  <= 1'b0;
            sck_rise <= 1'b0;
        end
        else
        begin
            sck_dly  <= sck_s;
            sck_rise <= sck_s & ~sck_dly;   // One clk wide
        end
    end

endmodule

//--- common/i2s_pkg.sv
package i2s_pkg;

    //////////////////////////////////////////////////////////////////////
    // Audio word format
    //////////////////////////////////////////////////////////////////////

    localparam int word_w = 16;                 // Bits per channel word

    // One stereo frame as it leaves the receiver
    typedef struct packed {
        logic [word_w-1:0] left;                // Channel sent while ws is low
        logic [word_w-1:0] right;               // Channel sent while ws is high
    } sample_t;

    //////////////////////////////////////////////////////////////////////
    // Self-test pattern setup
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [11:0] start_val;                 // First value after activation
        logic [7:0]  inc;                       // Step per frame
        logic [11:0] up_limit;                  // Wrap back above this value
    } bist_cfg_t;

    //////////////////////////////////////////////////////////////////////
    // Deserializer frame position
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ds_idle,                                // Waiting for a left word to start
        ds_left,                                // Shifting in the left word
        ds_right                                // Shifting in the right word
    } ds_state_e;

endpackage
